// ==== Bender.yml ====
package:
  name: wb_uart_tx

sources:
  - files:
      - logic/uart_pkg.sv
      - logic/uart_tx_fifo.sv
      - logic/uart_tx_engine.sv
      - logic/wb_uart_tx.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_uart.sv

// ==== dv/tb_uart_tasks.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Driver, compare and test tasks, included inside the UART testbench top.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic check_byte(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
        $display("error at %0t: %s, got %h, expected %h", $time, what, got, exp);
        error_cnt++;
    end
endtask

task automatic check_level(input logic [LEVEL_W-1:0] got, input logic [LEVEL_W-1:0] exp,
                           input string what);
    if (got !== exp) begin
        $display("error at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
        error_cnt++;
    end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        $display("error at %0t: %s, got %b, expected %b", $time, what, got, exp);
        error_cnt++;
    end
endtask

task automatic check_count(input int unsigned got, input int unsigned exp, input string what);
    if (got != exp) begin
        $display("error at %0t: %s, got %0d cycles, expected %0d", $time, what, got, exp);
        error_cnt++;
    end
endtask

task automatic clear_records();
    sent_q.delete();
    rx_q.delete();
    start_q.delete();
    stop_rise_q.delete();
endtask

// hold the strobe until every byte is acknowledged.
task automatic write_burst(input data_t bytes[$]);
    int idx;
    idx = 0;
    @(posedge clk);
    dat <= bytes[0];
    stb <= 1'b1;
    we  <= 1'b1;
    while (idx < bytes.size()) begin
        @(posedge clk);
        if (ack) begin                          // byte taken at this edge.
            sent_q.push_back(bytes[idx]);
            idx++;
            if (idx < bytes.size()) begin
                dat <= bytes[idx];
            end else begin
                stb <= 1'b0;
                we  <= 1'b0;
            end
        end
    end
endtask

task automatic wait_frames(input int unsigned count);
    while (rx_q.size() < count) begin
        @(posedge clk);
    end
    while (mon_state != uart_pkg::TX_IDLE) begin
        @(posedge clk);
    end
endtask

task automatic compare_streams(input string what);
    if (rx_q.size() != sent_q.size()) begin
        $display("%s: %0d bytes were written but %0d arrived on the line",
                 what, sent_q.size(), rx_q.size());
        error_cnt++;
    end else begin
        foreach (sent_q[i]) begin
            check_byte(rx_q[i], sent_q[i], what);
        end
    end
    sent_q.delete();
    rx_q.delete();
endtask

task automatic test_reset_state();
    @(posedge clk);
    check_bit(tx, 1'b1, "line after reset");
    check_level(size, '0, "level after reset");
    check_bit(ack, 1'b0, "ack without strobe");
endtask

task automatic test_single_frame();
    data_t bytes[$];
    data_t value;
    clear_records();
    @(posedge clk);
    prescaler <= PRESCALER_WIDTH'(P_SINGLE);
    value = data_t'($random(seed));
    value[uart_pkg::DATA_WIDTH-1] = 1'b0;       // msb low, so the stop bit is the last rise.
    bytes.push_back(value);
    write_burst(bytes);
    wait_frames(1);
    repeat (FRAME_BITS * (P_SINGLE + 1)) @(posedge clk);
    if (stop_rise_q.size() == 1) begin
        check_count(stop_rise_q[0] + P_SINGLE + 1, FRAME_BITS * (P_SINGLE + 1),
                    "single frame length");
    end
    compare_streams("single frame");
endtask

task automatic test_bursts();
    data_t bytes[$];
    int    len;
    clear_records();
    @(posedge clk);
    prescaler <= PRESCALER_WIDTH'(P_BURST);
    for (int b = 0; b < BURSTS; b++) begin
        len = 1 + ($unsigned($random(seed)) % BURST_MAX);
        bytes.delete();
        for (int i = 0; i < len; i++) begin
            bytes.push_back(data_t'($random(seed)));
        end
        write_burst(bytes);
    end
    wait_frames(sent_q.size());
    compare_streams("bursts");
endtask

task automatic test_back_pressure();
    data_t              bytes[$];
    logic [LEVEL_W-1:0] max_level;
    logic               writing;
    logic               stalled;
    clear_records();
    @(posedge clk);
    prescaler <= PRESCALER_WIDTH'(P_FULL);
    for (int i = 0; i < FULL_BYTES; i++) begin
        bytes.push_back(data_t'($random(seed)));
    end
    max_level = '0;
    writing   = 1'b1;
    stalled   = 1'b0;
    fork
        begin
            write_burst(bytes);
            writing = 1'b0;
        end
        begin
            while (writing) begin
                @(posedge clk);
                if (size > max_level) begin
                    max_level = size;
                end
                if (size == BUFFER && stb) begin
                    check_bit(ack, 1'b0, "ack while full");
                    stalled = 1'b1;
                end
            end
        end
    join
    check_level(max_level, LEVEL_W'(BUFFER), "peak level");
    check_bit(stalled, 1'b1, "write stalled on a full buffer");
    wait_frames(FULL_BYTES);
    compare_streams("back-pressure");
    check_level(size, '0, "level after draining");
endtask

task automatic test_clear();
    data_t bytes[$];
    clear_records();
    @(posedge clk);
    prescaler <= PRESCALER_WIDTH'(P_CLEAR);
    for (int i = 0; i < CLEAR_BYTES; i++) begin
        bytes.push_back(data_t'($random(seed)));
    end
    write_burst(bytes);
    @(posedge clk);
    check_level(size, LEVEL_W'(CLEAR_BYTES - 1), "level before clear");
    clear <= 1'b1;
    @(posedge clk);
    clear <= 1'b0;
    @(posedge clk);
    check_level(size, '0, "level after clear");
    sent_q.delete();
    sent_q.push_back(bytes[0]);                 // only the frame in flight survives.
    wait_frames(1);
    repeat (FRAME_BITS * (P_CLEAR + 1)) @(posedge clk);
    compare_streams("clear");
endtask

task automatic send_two_frames(input int unsigned presc);
    data_t bytes[$];
    clear_records();
    @(posedge clk);
    prescaler <= PRESCALER_WIDTH'(presc);
    bytes.push_back(data_t'($random(seed)));
    bytes.push_back(data_t'($random(seed)));
    write_burst(bytes);
    wait_frames(2);
    if (start_q.size() != 2) begin
        $display("prescaler %0d: expected 2 start bits but saw %0d", presc, start_q.size());
        error_cnt++;
    end else begin
        check_count(start_q[1] - start_q[0], FRAME_BITS * (presc + 1), "frame length");
    end
    compare_streams("prescaler change");
endtask

task automatic test_prescaler_change();
    send_two_frames(P_FAST);
    send_two_frames(P_SLOW);
endtask

// ==== dv/tb_uart.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench top for the buffered UART transmitter with clock, reset, line
// monitor and test sequence. Run it as the top with list.f.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_uart;

    localparam int BUFFER          = 8;
    localparam int PRESCALER_WIDTH = 12;
    localparam int LEVEL_W         = $clog2(BUFFER) + 1;
    localparam int FRAME_BITS      = uart_pkg::FRAME_BITS;

    // prescaler per test and stimulus sizes.
    localparam int P_SINGLE    = 7;
    localparam int P_BURST     = 4;
    localparam int P_FULL      = 63;
    localparam int P_CLEAR     = 15;
    localparam int P_FAST      = 3;
    localparam int P_SLOW      = 20;
    localparam int BURSTS      = 20;
    localparam int BURST_MAX   = 7;
    localparam int FULL_BYTES  = 10;
    localparam int CLEAR_BYTES = 5;

    // frame time of every planned byte with bursts counted at their longest.
    localparam int PLANNED_CYCLES = FRAME_BITS * (P_SINGLE + 1)
                                  + BURSTS * BURST_MAX * FRAME_BITS * (P_BURST + 1)
                                  + FULL_BYTES * FRAME_BITS * (P_FULL + 1)
                                  + CLEAR_BYTES * FRAME_BITS * (P_CLEAR + 1)
                                  + 2 * FRAME_BITS * (P_FAST + 1)
                                  + 2 * FRAME_BITS * (P_SLOW + 1);
    localparam int TIMEOUT_CYCLES = 2 * PLANNED_CYCLES + 1000;

    typedef logic [uart_pkg::DATA_WIDTH-1:0] data_t;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic [PRESCALER_WIDTH-1:0] prescaler;
    logic                       clear;
    data_t                      dat;
    logic                       we;
    logic                       stb;
    logic                       ack;
    logic [LEVEL_W-1:0]         size;
    logic                       tx;

    integer      seed      = 88540;
    int unsigned error_cnt = 0;
    int unsigned cycle_cnt = 0;

    data_t       sent_q[$];                     // bytes acknowledged by the DUT.
    data_t       rx_q[$];                       // bytes decoded from the line.
    int unsigned start_q[$];                    // monitor cycle of each start edge.
    int unsigned stop_rise_q[$];                // last rising edge inside each frame.

    // line monitor state is updated on the falling clock edge.
    uart_pkg::tx_state_e mon_state = uart_pkg::TX_IDLE;
    int unsigned         mon_cycle = 0;
    int unsigned         mon_start;
    int unsigned         mon_period;
    int unsigned         mon_pos;
    int unsigned         mon_rise;
    data_t               mon_data;
    logic                mon_prev  = 1'b1;

    wb_uart_tx #(
        .BUFFER          (BUFFER),
        .PRESCALER_WIDTH (PRESCALER_WIDTH)
    ) uut (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .prescaler_i (prescaler),
        .clear_i     (clear),
        .dat_i       (dat),
        .we_i        (we),
        .stb_i       (stb),
        .ack_o       (ack),
        .size_o      (size),
        .tx_o        (tx)
    );

    `include "tb_uart_tasks.svh"

    always #2 clk = ~clk;                       // 4 ns period.

    // decode frames at mid-bit and check that every edge sits on a bit boundary.
    always @(negedge clk) begin
        if (!rst_n) begin
            mon_state = uart_pkg::TX_IDLE;
        end else if (mon_state == uart_pkg::TX_IDLE) begin
            mon_cycle = mon_cycle + 1;
            if (!tx) begin
                mon_state  = uart_pkg::TX_START;
                mon_start  = mon_cycle;
                mon_period = prescaler + 1;
                mon_rise   = 0;
                mon_data   = '0;
                start_q.push_back(mon_cycle);
            end
        end else begin
            mon_cycle = mon_cycle + 1;
            mon_pos   = mon_cycle - mon_start;
            if (tx !== mon_prev && (mon_pos % mon_period) != 0) begin
                $display("error at %0t: line edge %0d cycles into bit %0d", $time,
                         mon_pos % mon_period, mon_pos / mon_period);
                error_cnt++;
            end
            if (tx && !mon_prev) begin
                mon_rise = mon_pos;
            end
            if ((mon_pos % mon_period) == mon_period / 2) begin
                if (mon_pos / mon_period == 0) begin
                    check_bit(tx, 1'b0, "start bit");
                end else if (mon_pos / mon_period <= uart_pkg::DATA_WIDTH) begin
                    mon_data[mon_pos / mon_period - 1] = tx;
                    mon_state = uart_pkg::TX_DATA;
                end else begin
                    check_bit(tx, 1'b1, "stop bit");
                    rx_q.push_back(mon_data);
                    stop_rise_q.push_back(mon_rise);
                    mon_state = uart_pkg::TX_STOP;
                end
            end
            if (mon_pos == FRAME_BITS * mon_period - 1) begin
                mon_state = uart_pkg::TX_IDLE;  // stop bit complete.
            end
        end
        mon_prev = tx;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests were still running after %0d cycles", cycle_cnt);
            $display("errors: %0d", error_cnt + 1);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        rst_n     = 1'b0;
        prescaler = '0;
        clear     = 1'b0;
        dat       = '0;
        we        = 1'b0;
        stb       = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        test_reset_state();
        test_single_frame();
        test_bursts();
        test_back_pressure();
        test_clear();
        test_prescaler_change();

        @(posedge clk);
        $display("errors: %0d", error_cnt);
        if (error_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+dv
logic/uart_pkg.sv
logic/uart_tx_fifo.sv
logic/uart_tx_engine.sv
logic/wb_uart_tx.sv
dv/tb_uart.sv

// ==== logic/uart_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame constants and transmit state encoding for the UART transmitter.
// Referenced by scoped name from the RTL and the testbench.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package uart_pkg;

    // a frame is one start bit, the data bits lsb first and one stop bit.
    localparam int DATA_WIDTH = 8;                  // data bits per frame.
    localparam int FRAME_BITS = DATA_WIDTH + 2;     // start + data + stop.

    // serializer states, one per section of the frame.
    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,                            // line high, waiting for a byte.
        TX_START = 2'd1,                            // driving the low start bit.
        TX_DATA  = 2'd2,                            // shifting out data bits.
        TX_STOP  = 2'd3                             // holding the high stop bit.
    } tx_state_e;

endpackage

// ==== logic/uart_tx_engine.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame serializer that pops bytes from the FIFO and drives the serial line.
// Every bit is held for prescaler_i + 1 clock cycles.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uart_tx_engine #(
    parameter int PRESCALER_WIDTH = 12
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic [PRESCALER_WIDTH-1:0]      prescaler_i,    // cycles per bit minus one.
    input  logic                            ready_i,        // FIFO holds a byte.
    input  logic [uart_pkg::DATA_WIDTH-1:0] data_i,         // FIFO head.
    output logic                            pop_o,
    output logic                            tx_o
);

    localparam int IDX_W = $clog2(uart_pkg::DATA_WIDTH);
    localparam logic [IDX_W-1:0] LAST_BIT = IDX_W'(uart_pkg::DATA_WIDTH - 1);

    uart_pkg::tx_state_e             state_q;
    logic [PRESCALER_WIDTH-1:0]      bit_cnt_q;             // cycles left in this bit.
    logic [uart_pkg::DATA_WIDTH-1:0] shift_q;
    logic [IDX_W-1:0]                bit_idx_q;
    logic                            tx_q;
    logic                            bit_done;
    logic                            frame_free;
    logic                            shift_en;

    assign bit_done = (bit_cnt_q == '0);

    // The last stop cycle can launch the next frame directly, so queued
    // bytes go out back to back with no extra idle cycle in between.
    assign frame_free = (state_q == uart_pkg::TX_IDLE) ||
                        (state_q == uart_pkg::TX_STOP && bit_done);
    assign pop_o      = frame_free & ready_i;

    // advance the shift register whenever a new data bit goes on the line.
    assign shift_en = bit_done &&
                      ((state_q == uart_pkg::TX_START) ||
                       (state_q == uart_pkg::TX_DATA && bit_idx_q != LAST_BIT));

    assign tx_o = tx_q;

    // bit 0 of the byte being serialized is always the next one out.
    always_ff @(posedge clk) begin
        if (pop_o) begin
            shift_q <= data_i;
        end else if (shift_en) begin
            shift_q <= {1'b0, shift_q[uart_pkg::DATA_WIDTH-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q   <= uart_pkg::TX_IDLE;
            bit_cnt_q <= '0;
            bit_idx_q <= '0;
            tx_q      <= 1'b1;                              // line idles high.
        end else begin
            case (state_q)
                uart_pkg::TX_IDLE: begin
                    if (pop_o) begin
                        state_q   <= uart_pkg::TX_START;
                        bit_cnt_q <= prescaler_i;
                        tx_q      <= 1'b0;                  // start bit.
                    end
                end

                uart_pkg::TX_START: begin
                    if (bit_done) begin
                        state_q   <= uart_pkg::TX_DATA;
                        bit_cnt_q <= prescaler_i;
                        bit_idx_q <= '0;
                        tx_q      <= shift_q[0];            // lsb first.
                    end else begin
                        bit_cnt_q <= bit_cnt_q - 1'b1;
                    end
                end

                uart_pkg::TX_DATA: begin
                    if (bit_done) begin
                        bit_cnt_q <= prescaler_i;
                        if (bit_idx_q == LAST_BIT) begin
                            state_q <= uart_pkg::TX_STOP;
                            tx_q    <= 1'b1;                // stop bit.
                        end else begin
                            bit_idx_q <= bit_idx_q + 1'b1;
                            tx_q      <= shift_q[0];
                        end
                    end else begin
                        bit_cnt_q <= bit_cnt_q - 1'b1;
                    end
                end

                uart_pkg::TX_STOP: begin
                    if (bit_done) begin
                        if (pop_o) begin
                            state_q   <= uart_pkg::TX_START;
                            bit_cnt_q <= prescaler_i;
                            tx_q      <= 1'b0;
                        end else begin
                            state_q <= uart_pkg::TX_IDLE;
                        end
                    end else begin
                        bit_cnt_q <= bit_cnt_q - 1'b1;
                    end
                end

                default: begin
                    state_q <= uart_pkg::TX_IDLE;
                    tx_q    <= 1'b1;
                end
            endcase
        end
    end

endmodule

// ==== logic/uart_tx_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Synchronous first-word fall-through FIFO for queued transmit bytes.
// Reports its fill level and can be flushed in a single cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uart_tx_fifo #(
    parameter int BUFFER = 256                              // depth, power of two.
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            clear_i,        // flush all entries.
    input  logic                            push_i,
    input  logic [uart_pkg::DATA_WIDTH-1:0] push_data_i,
    input  logic                            pop_i,
    output logic [uart_pkg::DATA_WIDTH-1:0] pop_data_o,     // head entry when not empty.
    output logic                            empty_o,
    output logic                            full_o,
    output logic [$clog2(BUFFER):0]         count_o
);

    localparam int PTR_W = $clog2(BUFFER);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(BUFFER);

    logic [uart_pkg::DATA_WIDTH-1:0] mem [BUFFER];
    logic [PTR_W-1:0]                wr_ptr_q;
    logic [PTR_W-1:0]                rd_ptr_q;
    logic [PTR_W:0]                  count_q;
    logic                            do_push;
    logic                            do_pop;

    // a flush wins over a push in the same cycle.
    assign do_push = push_i & ~full_o & ~clear_i;
    assign do_pop  = pop_i & ~empty_o;

    assign empty_o    = (count_q == '0);
    assign full_o     = (count_q == FULL_COUNT);
    assign count_o    = count_q;
    assign pop_data_o = mem[rd_ptr_q];                      // fall-through read.

    // storage array.
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    // pointers wrap naturally since the depth is a power of two.
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else if (clear_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // occupancy tracking.
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (clear_i) begin
            count_q <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;        // idle, or push and pop together.
            endcase
        end
    end

endmodule

// ==== logic/wb_uart_tx.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Transmit-only UART with a write buffer behind a Wishbone-style port.
// BUFFER and PRESCALER_WIDTH are set here and passed to the submodules.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module wb_uart_tx #(
    parameter int BUFFER          = 256,                    // FIFO depth, power of two.
    parameter int PRESCALER_WIDTH = 12
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic [PRESCALER_WIDTH-1:0]      prescaler_i,    // bit period minus one.
    input  logic                            clear_i,        // flush queued bytes.
    input  logic [uart_pkg::DATA_WIDTH-1:0] dat_i,
    input  logic                            we_i,
    input  logic                            stb_i,
    output logic                            ack_o,
    output logic [$clog2(BUFFER):0]         size_o,         // bytes waiting.
    output logic                            tx_o            // serial line.
);

    logic                            fifo_push;
    logic                            fifo_pop;
    logic                            fifo_full;
    logic                            fifo_empty;
    logic [uart_pkg::DATA_WIDTH-1:0] fifo_data;

    // zero-latency acknowledge, held off while the buffer is full.
    assign ack_o     = stb_i & we_i & ~fifo_full;
    assign fifo_push = ack_o;                               // accepted write is stored.

    uart_tx_fifo #(
        .BUFFER(BUFFER)
    ) u_fifo (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .clear_i     (clear_i),
        .push_i      (fifo_push),
        .push_data_i (dat_i),
        .pop_i       (fifo_pop),
        .pop_data_o  (fifo_data),
        .empty_o     (fifo_empty),
        .full_o      (fifo_full),
        .count_o     (size_o)
    );

    uart_tx_engine #(
        .PRESCALER_WIDTH(PRESCALER_WIDTH)
    ) u_engine (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .prescaler_i (prescaler_i),
        .ready_i     (~fifo_empty),
        .data_i      (fifo_data),
        .pop_o       (fifo_pop),
        .tx_o        (tx_o)
    );

endmodule
